// ==== exu.f ====
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_alu.sv
rtl/exu_mul_prep.sv
rtl/exu_mul_stage.sv
rtl/exu_mul_final.sv
rtl/exu_top.sv
tests/exu_tb.sv

// ==== rtl/exu_alu.sv ====
module exu_alu import exu_pkg::*; (
  input  alu_ctl_t    ctl_i,
  input  logic [63:0] a_i,
  input  logic [63:0] b_i,
  output logic [63:0] res_o
);

  logic [5:0]  shamt;
  logic [63:0] srl_src;
  logic [63:0] sra_src;
  logic [63:0] raw;

  // word forms shift only the low word, 5-bit amount
  always_comb begin
    if (ctl_i.word) begin
      shamt   = {1'b0, b_i[4:0]};
      srl_src = {32'b0, a_i[31:0]};
      sra_src = {{32{a_i[31]}}, a_i[31:0]};
    end else begin
      shamt   = b_i[5:0];
      srl_src = a_i;
      sra_src = a_i;
    end
  end

  always_comb begin
    case (ctl_i.op)
      alu_add:    raw = a_i + b_i;
      alu_sub:    raw = a_i - b_i;
      alu_sll:    raw = a_i << shamt;
      alu_slt:    raw = {63'b0, $signed(a_i) < $signed(b_i)};
      alu_sltu:   raw = {63'b0, a_i < b_i};
      alu_xor:    raw = a_i ^ b_i;
      alu_srl:    raw = srl_src >> shamt;
      alu_sra:    raw = $signed(sra_src) >>> shamt;
      alu_or:     raw = a_i | b_i;
      alu_and:    raw = a_i & b_i;
      alu_beq:    raw = {63'b0, a_i == b_i};
      alu_bne:    raw = {63'b0, a_i != b_i};
      alu_blt:    raw = {63'b0, $signed(a_i) < $signed(b_i)};
      alu_bge:    raw = {63'b0, $signed(a_i) >= $signed(b_i)};
      alu_bltu:   raw = {63'b0, a_i < b_i};
      alu_bgeu:   raw = {63'b0, a_i >= b_i};
      alu_pass_b: raw = b_i;  // lui
      default:    raw = '0;
    endcase

    res_o = raw;
    if (ctl_i.word) begin
      res_o = {{32{raw[31]}}, raw[31:0]};
    end
    if (ctl_i.clr_lsb) begin
      res_o[0] = 1'b0;  // jalr target
    end
  end

endmodule

// ==== rtl/exu_decode.sv ====
`include "exu_macros.svh"

module exu_decode import exu_pkg::*; (
  input  instr_u   instr_i,
  output alu_ctl_t ctl_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        alt;  // bit 30, sub / sra
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_u;

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sel_alt);
    alu_op_e op;
    case (f3)
      `EXU_F3_ADD:  op = sel_alt ? alu_sub : alu_add;
      `EXU_F3_SLL:  op = alu_sll;
      `EXU_F3_SLT:  op = alu_slt;
      `EXU_F3_SLTU: op = alu_sltu;
      `EXU_F3_XOR:  op = alu_xor;
      `EXU_F3_SR:   op = sel_alt ? alu_sra : alu_srl;
      `EXU_F3_OR:   op = alu_or;
      default:      op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = instr_i.r.opcode;
  assign funct3 = instr_i.r.funct3;
  assign alt    = instr_i.r.funct7[5];

  assign imm_i = {{52{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s = {{52{instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rd};
  assign imm_u = {{32{instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rs2,
                  instr_i.r.rs1, instr_i.r.funct3, 12'b0};

  always_comb begin
    ctl_o     = '0;
    ctl_o.op  = alu_zero;
    ctl_o.imm = imm_i;
    case (opcode)
      `EXU_OP_R, `EXU_OP_RW: begin
        ctl_o.word = (opcode == `EXU_OP_RW);
        if (instr_i.r.funct7 == `EXU_F7_MULDIV) begin
          ctl_o.is_mul = (funct3 == `EXU_F3_ADD);  // mulh/div/rem stay zero
        end else begin
          ctl_o.op = arith_op(funct3, alt);
        end
      end
      `EXU_OP_I, `EXU_OP_IW: begin
        ctl_o.word    = (opcode == `EXU_OP_IW);
        ctl_o.use_imm = 1'b1;
        ctl_o.op      = arith_op(funct3, alt && (funct3 == `EXU_F3_SR));
      end
      `EXU_OP_BR: begin
        case (funct3)
          3'b000:  ctl_o.op = alu_beq;
          3'b001:  ctl_o.op = alu_bne;
          3'b100:  ctl_o.op = alu_blt;
          3'b101:  ctl_o.op = alu_bge;
          3'b110:  ctl_o.op = alu_bltu;
          3'b111:  ctl_o.op = alu_bgeu;
          default: ctl_o.op = alu_zero;
        endcase
      end
      `EXU_OP_LUI: begin
        ctl_o.op      = alu_pass_b;
        ctl_o.use_imm = 1'b1;
        ctl_o.imm     = imm_u;
      end
      `EXU_OP_AUIPC: begin
        ctl_o.op      = alu_add;
        ctl_o.use_imm = 1'b1;
        ctl_o.use_pc  = 1'b1;
        ctl_o.imm     = imm_u;
      end
      `EXU_OP_LOAD, `EXU_OP_STORE: begin
        ctl_o.op      = alu_add;
        ctl_o.use_imm = 1'b1;
        if (opcode == `EXU_OP_STORE) ctl_o.imm = imm_s;
      end
      `EXU_OP_JAL: begin
        ctl_o.op      = alu_add;  // link value pc+4
        ctl_o.use_imm = 1'b1;
        ctl_o.use_pc  = 1'b1;
        ctl_o.imm     = 64'd4;
      end
      `EXU_OP_JALR: begin
        ctl_o.op      = alu_add;
        ctl_o.use_imm = 1'b1;
        ctl_o.clr_lsb = 1'b1;
      end
      `EXU_OP_SYS: ctl_o.op = alu_zero;
      default:     ctl_o.op = alu_zero;
    endcase
  end

endmodule

// ==== rtl/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// major opcodes
`define EXU_OP_R      7'b0110011
`define EXU_OP_I      7'b0010011
`define EXU_OP_RW     7'b0111011
`define EXU_OP_IW     7'b0011011
`define EXU_OP_BR     7'b1100011
`define EXU_OP_LUI    7'b0110111
`define EXU_OP_AUIPC  7'b0010111
`define EXU_OP_LOAD   7'b0000011
`define EXU_OP_STORE  7'b0100011
`define EXU_OP_JAL    7'b1101111
`define EXU_OP_JALR   7'b1100111
`define EXU_OP_SYS    7'b1110011

`define EXU_F7_MULDIV 7'b0000001

// funct3, arithmetic group
`define EXU_F3_ADD    3'b000
`define EXU_F3_SLL    3'b001
`define EXU_F3_SLT    3'b010
`define EXU_F3_SLTU   3'b011
`define EXU_F3_XOR    3'b100
`define EXU_F3_SR     3'b101
`define EXU_F3_OR     3'b110
`define EXU_F3_AND    3'b111

`define EXU_MUL_STAGES 4  // must divide 64

`endif

// ==== rtl/exu_mul_final.sv ====
module exu_mul_final import exu_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  mul_flow_t   flow_i,
  output logic        done_o,
  output logic [63:0] prod_o
);

  logic        done_q;
  logic [63:0] prod_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= flow_i.valid;  // one pulse per item
    end
  end

  always_ff @(posedge clk_i) begin
    if (flow_i.valid) begin
      prod_q <= flow_i.word ? {{32{flow_i.acc[31]}}, flow_i.acc[31:0]} : flow_i.acc;
    end
  end

  assign done_o = done_q;
  assign prod_o = prod_q;

endmodule

// ==== rtl/exu_mul_prep.sv ====
module exu_mul_prep import exu_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        start_i,
  input  logic        word_i,
  input  logic [63:0] a_i,
  input  logic [63:0] b_i,
  output mul_flow_t   flow_o
);

  logic        valid_q;
  logic        word_q;
  logic [63:0] mcand_q;
  logic [63:0] mplier_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      word_q   <= word_i;
      mcand_q  <= word_i ? {32'b0, a_i[31:0]} : a_i;  // low words only for mulw
      mplier_q <= word_i ? {32'b0, b_i[31:0]} : b_i;
    end
  end

  always_comb begin
    flow_o.valid  = valid_q;
    flow_o.word   = word_q;
    flow_o.mcand  = mcand_q;
    flow_o.mplier = mplier_q;
    flow_o.acc    = '0;
  end

endmodule

// ==== rtl/exu_mul_stage.sv ====
`include "exu_macros.svh"

module exu_mul_stage import exu_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  mul_flow_t flow_i,
  output mul_flow_t flow_o
);

  localparam int step_bits = 64 / `EXU_MUL_STAGES;

  logic        valid_q;
  logic [63:0] mcand_n;
  logic [63:0] mplier_n;
  logic [63:0] acc_n;
  mul_flow_t   data_q;

  // consume step_bits multiplier bits, lsb first
  always_comb begin
    mcand_n  = flow_i.mcand;
    mplier_n = flow_i.mplier;
    acc_n    = flow_i.acc;
    for (int k = 0; k < step_bits; k++) begin
      if (mplier_n[0]) acc_n = acc_n + mcand_n;
      mcand_n  = mcand_n << 1;
      mplier_n = mplier_n >> 1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= flow_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flow_i.valid) begin
      data_q <= '{valid: 1'b1, word: flow_i.word, mcand: mcand_n,
                  mplier: mplier_n, acc: acc_n};
    end
  end

  always_comb begin
    flow_o       = data_q;
    flow_o.valid = valid_q;
  end

endmodule

// ==== rtl/exu_pkg.sv ====
package exu_pkg;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu,
    alu_pass_b,
    alu_zero
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // same word, r view for funct7, i view for the immediate
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef struct packed {
    instr_u      instr;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] pc;
  } exu_req_t;

  typedef struct packed {
    alu_op_e     op;
    logic        word;
    logic        use_imm;
    logic        use_pc;
    logic        clr_lsb;
    logic        is_mul;
    logic [63:0] imm;
  } alu_ctl_t;

  typedef struct packed {
    logic        valid;
    logic        word;
    logic [63:0] mcand;
    logic [63:0] mplier;
    logic [63:0] acc;
  } mul_flow_t;

endpackage

// ==== rtl/exu_top.sv ====
`include "exu_macros.svh"

module exu_top import exu_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  exu_req_t    wb_dat_i,
  output logic        wb_ack_o,
  output logic [63:0] wb_dat_o
);

  alu_ctl_t    ctl;
  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] alu_res;
  logic [63:0] alu_res_q;
  logic        alu_ack_q;
  logic        pending_q;
  logic        accept;
  logic        mul_start;
  logic        mul_done;
  logic [63:0] mul_prod;
  mul_flow_t   flow [0:`EXU_MUL_STAGES];

  assign accept    = wb_cyc_i & wb_stb_i & ~pending_q;
  assign mul_start = accept & ctl.is_mul;

  assign op_a = ctl.use_pc ? wb_dat_i.pc : wb_dat_i.src1;
  assign op_b = ctl.use_imm ? ctl.imm : wb_dat_i.src2;

  exu_decode u_decode (
    .instr_i (wb_dat_i.instr),
    .ctl_o   (ctl)
  );

  exu_alu u_alu (
    .ctl_i (ctl),
    .a_i   (op_a),
    .b_i   (op_b),
    .res_o (alu_res)
  );

  exu_mul_prep u_mul_prep (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (mul_start),
    .word_i   (ctl.word),
    .a_i      (wb_dat_i.src1),
    .b_i      (wb_dat_i.src2),
    .flow_o   (flow[0])
  );

  for (genvar g = 0; g < `EXU_MUL_STAGES; g++) begin : g_stage
    exu_mul_stage u_mul_stage (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .flow_i   (flow[g]),
      .flow_o   (flow[g+1])
    );
  end

  exu_mul_final u_mul_final (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flow_i   (flow[`EXU_MUL_STAGES]),
    .done_o   (mul_done),
    .prod_o   (mul_prod)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
      alu_ack_q <= 1'b0;
    end else begin
      alu_ack_q <= accept & ~ctl.is_mul;
      if (accept) begin
        pending_q <= 1'b1;
      end else if (wb_ack_o) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) alu_res_q <= alu_res;
  end

  // only one of the two can be high, a single item is in flight
  assign wb_ack_o = alu_ack_q | mul_done;
  assign wb_dat_o = mul_done ? mul_prod : alu_res_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the exu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module exu_tb -f exu.f \
  --Mdir obj_dir -o exu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit $status
fi

./obj_dir/exu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// ==== tests/exu_tb.sv ====
`include "exu_macros.svh"

module exu_tb import exu_pkg::*; ();

  typedef struct packed {
    logic [31:0] instr;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] pc;
    logic [63:0] exp;
  } vec_t;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  exu_req_t    wb_dat_i;
  logic        wb_ack_o;
  logic [63:0] wb_dat_o;

  vec_t        vecs[$];
  logic [31:0] lfsr_q = 32'h8ff4;
  int          cycles = 0;
  int          limit = 200;

  exu_top dut_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_o (wb_ack_o),
    .wb_dat_o (wb_dat_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles without finishing the table", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] op);
    return {f7, 5'd2, 5'd1, f3, 5'd3, op};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] op);
    return {imm, 5'd1, f3, 5'd3, op};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [6:0] op);
    return {imm, 5'd3, op};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [6:0] op);
    return {imm[11:5], 5'd2, 5'd1, 3'b011, imm[4:0], op};
  endfunction

  // one galois step per bit taken
  function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic add_vec(input logic [31:0] instr, input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] pc, input logic [63:0] exp);
    vecs.push_back('{instr: instr, src1: a, src2: b, pc: pc, exp: exp});
  endtask

  task automatic check_res(input logic [63:0] got, input logic [63:0] exp, input int idx);
    if (got !== exp) begin
      $display("mismatch wb_dat_o entry %0d: got %h expected %h", idx, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "result check failed");
    end
  endtask

  task automatic check_idle(input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch wb_ack_o: got %h expected %h", got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "acknowledge check failed");
    end
  endtask

  task automatic fill_table();
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] p32;
    // register forms
    add_vec(r_word(7'h00, `EXU_F3_ADD, `EXU_OP_R), 64'h1234_5678_9abc_def0,
            64'h1111_1111_1111_1111, 64'h0, 64'h2345_6789_abcd_f001);
    add_vec(r_word(7'h20, `EXU_F3_ADD, `EXU_OP_R), 64'd5, 64'd7, 64'h0, '1 - 64'd1);
    add_vec(r_word(7'h00, `EXU_F3_SLL, `EXU_OP_R), 64'd1, 64'd63, 64'h0, 64'h8000_0000_0000_0000);
    add_vec(r_word(7'h00, `EXU_F3_SLT, `EXU_OP_R), '1, 64'd1, 64'h0, 64'd1);
    add_vec(r_word(7'h00, `EXU_F3_SLTU, `EXU_OP_R), '1, 64'd1, 64'h0, 64'd0);
    add_vec(r_word(7'h00, `EXU_F3_XOR, `EXU_OP_R), 64'hff00, 64'h0ff0, 64'h0, 64'hf0f0);
    add_vec(r_word(7'h00, `EXU_F3_SR, `EXU_OP_R), 64'h8000_0000_0000_0000, 64'd4, 64'h0,
            64'h0800_0000_0000_0000);
    add_vec(r_word(7'h20, `EXU_F3_SR, `EXU_OP_R), 64'h8000_0000_0000_0000, 64'd4, 64'h0,
            64'hf800_0000_0000_0000);
    add_vec(r_word(7'h00, `EXU_F3_OR, `EXU_OP_R), 64'hf0, 64'h0f, 64'h0, 64'hff);
    add_vec(r_word(7'h00, `EXU_F3_AND, `EXU_OP_R), 64'hff0f, 64'h0ff0, 64'h0, 64'h0f00);
    // immediate forms ignore src2
    add_vec(i_word(12'hfff, `EXU_F3_ADD, `EXU_OP_I), 64'd10, 64'd99, 64'h0, 64'd9);
    add_vec(i_word(12'hfff, `EXU_F3_SLTU, `EXU_OP_I), 64'd5, 64'd0, 64'h0, 64'd1);
    add_vec(i_word(12'h408, `EXU_F3_SR, `EXU_OP_I), 64'h8000_0000_0000_0000, 64'd0, 64'h0,
            64'hff80_0000_0000_0000);
    add_vec(i_word(12'h800, `EXU_F3_OR, `EXU_OP_I), 64'd1, 64'd0, 64'h0, 64'hffff_ffff_ffff_f801);
    // word forms
    add_vec(r_word(7'h00, `EXU_F3_ADD, `EXU_OP_RW), 64'h7fff_ffff, 64'd1, 64'h0,
            64'hffff_ffff_8000_0000);
    add_vec(r_word(7'h20, `EXU_F3_ADD, `EXU_OP_RW), 64'h1234_0000_0000_0000, 64'd1, 64'h0, '1);
    add_vec(r_word(7'h00, `EXU_F3_SLL, `EXU_OP_RW), 64'd1, 64'd31, 64'h0, 64'hffff_ffff_8000_0000);
    add_vec(r_word(7'h00, `EXU_F3_SR, `EXU_OP_RW), 64'hffff_ffff_8000_0000, 64'd36, 64'h0,
            64'h0000_0000_0800_0000);
    add_vec(r_word(7'h20, `EXU_F3_SR, `EXU_OP_RW), 64'h8000_0000, 64'd4, 64'h0,
            64'hffff_ffff_f800_0000);
    add_vec(i_word(12'h401, `EXU_F3_SR, `EXU_OP_IW), 64'h8000_0000, 64'd0, 64'h0,
            64'hffff_ffff_c000_0000);
    // branch compares
    add_vec(r_word(7'h00, 3'b000, `EXU_OP_BR), 64'd5, 64'd5, 64'h0, 64'd1);
    add_vec(r_word(7'h00, 3'b001, `EXU_OP_BR), 64'd5, 64'd5, 64'h0, 64'd0);
    add_vec(r_word(7'h00, 3'b100, `EXU_OP_BR), '1, 64'd1, 64'h0, 64'd1);
    add_vec(r_word(7'h00, 3'b101, `EXU_OP_BR), '1, 64'd1, 64'h0, 64'd0);
    add_vec(r_word(7'h00, 3'b110, `EXU_OP_BR), '1, 64'd1, 64'h0, 64'd0);
    add_vec(r_word(7'h00, 3'b111, `EXU_OP_BR), '1, 64'd1, 64'h0, 64'd1);
    // upper immediates, addresses and links
    add_vec(u_word(20'h12345, `EXU_OP_LUI), 64'd7, 64'd7, 64'h0, 64'h1234_5000);
    add_vec(u_word(20'h80000, `EXU_OP_LUI), 64'd0, 64'd0, 64'h0, 64'hffff_ffff_8000_0000);
    add_vec(u_word(20'h00001, `EXU_OP_AUIPC), 64'd0, 64'd0, 64'h1000, 64'h2000);
    add_vec(s_word(12'hff0, `EXU_OP_STORE), 64'h2000, 64'd0, 64'h0, 64'h1ff0);
    add_vec(u_word(20'h00000, `EXU_OP_JAL), 64'd0, 64'd0, 64'h4000, 64'h4004);
    add_vec(i_word(12'h003, 3'b000, `EXU_OP_JALR), 64'h1000, 64'd0, 64'h0, 64'h1002);
    add_vec(32'h0000_0073, 64'd3, 64'd4, 64'h0, 64'd0);
    // multiplier with fixed then random operands
    add_vec(r_word(`EXU_F7_MULDIV, 3'b000, `EXU_OP_R), '1, 64'd7, 64'h0, '1 - 64'd6);
    add_vec(r_word(`EXU_F7_MULDIV, 3'b000, `EXU_OP_RW), 64'h7fff_ffff, 64'd2, 64'h0,
            64'hffff_ffff_ffff_fffe);
    for (int n = 0; n < 4; n++) begin
      a = rand_bits(64);
      b = rand_bits(64);
      add_vec(r_word(`EXU_F7_MULDIV, 3'b000, `EXU_OP_R), a, b, 64'h0, a * b);
      a = rand_bits(64);
      b = rand_bits(64);
      p32 = a[31:0] * b[31:0];  // low word of the product
      add_vec(r_word(`EXU_F7_MULDIV, 3'b000, `EXU_OP_RW), a, b, 64'h0, {{32{p32[31]}}, p32});
    end
    a = rand_bits(64);
    b = rand_bits(64);
    add_vec(r_word(7'h00, `EXU_F3_ADD, `EXU_OP_R), a, b, 64'h0, a + b);
  endtask

  task automatic run_vec(input vec_t v, input int idx);
    exu_req_t req;
    req.instr = v.instr;
    req.src1  = v.src1;
    req.src2  = v.src2;
    req.pc    = v.pc;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_dat_i <= req;
    @(negedge clk_i);
    while (wb_ack_o !== 1'b1) @(negedge clk_i);
    check_res(wb_dat_o, v.exp, idx);
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    @(negedge clk_i);
    check_idle(wb_ack_o, 1'b0);  // single pulse
    @(negedge clk_i);
    check_idle(wb_ack_o, 1'b0);
  endtask

  initial begin
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_dat_i = '0;
    fill_table();
    limit = vecs.size() * (`EXU_MUL_STAGES + 6) + 200;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_idle(wb_ack_o, 1'b0);
    for (int i = 0; i < vecs.size(); i++) begin
      run_vec(vecs[i], i);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
